// ==== hdl/intr_bus_pkg.sv ====
`default_nettype none

package intr_bus_pkg;

    // Mode field, the two low bits of a command word.
    typedef enum logic [1:0] {
        none = 2'b00, // No mode selected, word is ignored.
        poll = 2'b01, // Rotating poll over all sources.
        prio = 2'b10  // Ranked mode, four table words follow.
    } intr_mode_e;

    typedef logic [4:0] vec_code_t; // Condition code in the top five bits.

    // Vector codes sent by the controller after the first acknowledge.
    localparam vec_code_t POLL_VEC_CODE  = 5'b01011;
    localparam vec_code_t PRIO_VEC_CODE  = 5'b10011;

    // Done codes expected from the processor once the handler has finished.
    localparam vec_code_t POLL_DONE_CODE = 5'b10100;
    localparam vec_code_t PRIO_DONE_CODE = 5'b01100;

    // Command word with two ranked source IDs.
    typedef struct packed {
        logic [2:0] hi_id; // Higher of the two ranks.
        logic [2:0] lo_id; // Next rank down.
        intr_mode_e mode;
    } cmd_word_t;

    // Vector and done words.
    typedef struct packed {
        vec_code_t  code;
        logic [2:0] id;   // Source the word refers to.
    } msg_word_t;

    // One bus word with both decodings.
    typedef union packed {
        cmd_word_t cmd;
        msg_word_t msg;
    } bus_word_u;

endpackage

`default_nettype wire

// ==== hdl/intr_ctrl_pkg.sv ====
`default_nettype none

package intr_ctrl_pkg;

    localparam int SRC_COUNT = 8; // Request lines, fixed by the 3-bit ID field.

    typedef logic [2:0] src_id_t;

    // Controller states.
    typedef enum logic [3:0] {
        reset      = 4'd0,  // Clear mode and table counter.
        cmd        = 4'd1,  // Wait for command words.
        jump       = 4'd2,  // Clear poll index, branch on mode.
        poll_scan  = 4'd3,  // Test one source per cycle.
        poll_raise = 4'd4,  // intr_out high until first acknowledge.
        poll_vec   = 4'd5,  // Vector on the bus until second acknowledge.
        poll_done  = 4'd6,  // Wait for the done word.
        prio_scan  = 4'd7,  // Wait for any ranked request.
        prio_raise = 4'd8,
        prio_vec   = 4'd9,
        prio_done  = 4'd10
    } intr_state_e;

    // Result of the ranked request search.
    typedef struct packed {
        logic    hit; // Some ranked source is requesting.
        src_id_t id;  // Highest-ranked requesting source.
    } grant_t;

endpackage

`default_nettype wire

// ==== hdl/poll_counter.sv ====
`default_nettype none

module poll_counter (
    input  wire                    clk_in,
    input  wire                    rst_in,
    input  wire                    poll_clear, // Restart at source 0.
    input  wire                    poll_step,  // Move to the next source.
    output intr_ctrl_pkg::src_id_t poll_idx
);

    // Index wraps from 7 back to 0 by plain overflow.
    always_ff @(posedge clk_in or posedge rst_in) begin
        if (rst_in) begin
            poll_idx <= '0;
        end else if (poll_clear) begin
            poll_idx <= '0; // Clear wins over step.
        end else if (poll_step) begin
            poll_idx <= poll_idx + 3'd1;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/priority_table.sv ====
`default_nettype none

module priority_table (
    input  wire                                clk_in,
    input  wire                                rst_in,
    input  wire                                table_clear, // Restart loading at rank 0.
    input  wire                                table_load,  // Bus word carries the next pair.
    input  wire intr_bus_pkg::bus_word_u       bus_in,
    input  wire [intr_ctrl_pkg::SRC_COUNT-1:0] intr_rq,
    output intr_ctrl_pkg::grant_t              grant,
    output logic                               load_done    // Fourth pair is going in.
);

    intr_ctrl_pkg::src_id_t rank_q [intr_ctrl_pkg::SRC_COUNT]; // Rank 0 is served first.
    logic [1:0]             load_cnt_q;                        // Which pair comes next.

    // Load counter.
    always_ff @(posedge clk_in or posedge rst_in) begin
        if (rst_in) begin
            load_cnt_q <= '0;
        end else if (table_clear) begin
            load_cnt_q <= '0;
        end else if (table_load) begin
            load_cnt_q <= load_cnt_q + 2'd1; // Wraps after the fourth word.
        end
    end

    // Ranks are plain storage, written two at a time.
    always_ff @(posedge clk_in) begin
        if (table_load && !table_clear) begin
            rank_q[{load_cnt_q, 1'b0}] <= bus_in.cmd.hi_id;
            rank_q[{load_cnt_q, 1'b1}] <= bus_in.cmd.lo_id;
        end
    end

    assign load_done = table_load && (load_cnt_q == 2'b11);

    // Walk from the lowest rank up so the highest active rank is left standing.
    always_comb begin
        grant = '0;
        for (int i = intr_ctrl_pkg::SRC_COUNT - 1; i >= 0; i--) begin
            if (intr_rq[rank_q[i]]) begin
                grant.hit = 1'b1;
                grant.id  = rank_q[i];
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/intr_fsm.sv ====
`default_nettype none

module intr_fsm (
    input  wire                                clk_in,
    input  wire                                rst_in,
    input  wire [intr_ctrl_pkg::SRC_COUNT-1:0] intr_rq,
    input  wire intr_bus_pkg::bus_word_u       bus_in,
    input  wire                                intr_in,    // Active-low acknowledge.
    input  wire intr_ctrl_pkg::src_id_t        poll_idx,
    input  wire intr_ctrl_pkg::grant_t         grant,
    input  wire                                load_done,
    output logic                               poll_clear,
    output logic                               poll_step,
    output logic                               table_clear,
    output logic                               table_load,
    output logic                               intr_out,
    output intr_bus_pkg::bus_word_u            bus_out,
    output logic                               bus_oe
);

    intr_ctrl_pkg::intr_state_e state_q, state_d;
    intr_bus_pkg::intr_mode_e   mode_q, mode_d;       // Mode chosen by the last command.
    intr_ctrl_pkg::src_id_t     served_q, served_d;   // Source being served.
    logic                       intr_out_d;
    logic                       bus_oe_d;
    intr_bus_pkg::bus_word_u    bus_out_d;
    logic                       ack;                  // Processor strobe this cycle.

    assign ack = !intr_in;

    always_comb begin
        state_d     = state_q;
        mode_d      = mode_q;
        served_d    = served_q;
        intr_out_d  = intr_out;
        bus_oe_d    = bus_oe;
        bus_out_d   = bus_out;
        poll_clear  = 1'b0;
        poll_step   = 1'b0;
        table_clear = 1'b0;
        table_load  = 1'b0;

        case (state_q)
            intr_ctrl_pkg::reset: begin
                mode_d      = intr_bus_pkg::none;
                intr_out_d  = 1'b0;
                bus_oe_d    = 1'b0;
                poll_clear  = 1'b1;
                table_clear = 1'b1; // Next priority word lands in ranks 0 and 1.
                state_d     = intr_ctrl_pkg::cmd;
            end
            intr_ctrl_pkg::cmd: begin
                case (bus_in.cmd.mode)
                    intr_bus_pkg::poll: begin
                        mode_d  = intr_bus_pkg::poll;
                        state_d = intr_ctrl_pkg::jump;
                    end
                    intr_bus_pkg::prio: begin
                        table_load = 1'b1; // One pair per word.
                        if (load_done) begin
                            mode_d  = intr_bus_pkg::prio;
                            state_d = intr_ctrl_pkg::jump;
                        end
                    end
                    default: ; // Other mode bits are ignored.
                endcase
            end
            intr_ctrl_pkg::jump: begin
                poll_clear = 1'b1; // Polling always starts at source 0.
                case (mode_q)
                    intr_bus_pkg::poll: state_d = intr_ctrl_pkg::poll_scan;
                    intr_bus_pkg::prio: state_d = intr_ctrl_pkg::prio_scan;
                    default:            state_d = intr_ctrl_pkg::reset;
                endcase
            end
            intr_ctrl_pkg::poll_scan: begin
                if (intr_rq[poll_idx]) begin
                    served_d   = poll_idx; // Index holds, so polling resumes here.
                    intr_out_d = 1'b1;
                    state_d    = intr_ctrl_pkg::poll_raise;
                end else begin
                    poll_step = 1'b1;
                end
            end
            intr_ctrl_pkg::prio_scan: begin
                if (grant.hit) begin
                    served_d   = grant.id;
                    intr_out_d = 1'b1;
                    state_d    = intr_ctrl_pkg::prio_raise;
                end
            end
            intr_ctrl_pkg::poll_raise, intr_ctrl_pkg::prio_raise: begin
                if (ack) begin
                    intr_out_d       = 1'b0;
                    bus_oe_d         = 1'b1;
                    bus_out_d.msg.id = served_q;
                    if (state_q == intr_ctrl_pkg::poll_raise) begin
                        bus_out_d.msg.code = intr_bus_pkg::POLL_VEC_CODE;
                        state_d            = intr_ctrl_pkg::poll_vec;
                    end else begin
                        bus_out_d.msg.code = intr_bus_pkg::PRIO_VEC_CODE;
                        state_d            = intr_ctrl_pkg::prio_vec;
                    end
                end
            end
            intr_ctrl_pkg::poll_vec: begin
                if (ack) begin
                    bus_oe_d = 1'b0; // Release the bus.
                    state_d  = intr_ctrl_pkg::poll_done;
                end
            end
            intr_ctrl_pkg::prio_vec: begin
                if (ack) begin
                    bus_oe_d = 1'b0;
                    state_d  = intr_ctrl_pkg::prio_done;
                end
            end
            intr_ctrl_pkg::poll_done: begin
                if (ack) begin
                    // Either field wrong counts as a protocol error.
                    if (bus_in.msg.code == intr_bus_pkg::POLL_DONE_CODE &&
                        bus_in.msg.id == served_q) begin
                        state_d = intr_ctrl_pkg::poll_scan;
                    end else begin
                        state_d = intr_ctrl_pkg::reset;
                    end
                end
            end
            intr_ctrl_pkg::prio_done: begin
                if (ack) begin
                    if (bus_in.msg.code == intr_bus_pkg::PRIO_DONE_CODE &&
                        bus_in.msg.id == served_q) begin
                        state_d = intr_ctrl_pkg::prio_scan;
                    end else begin
                        state_d = intr_ctrl_pkg::reset;
                    end
                end
            end
            default: begin
                intr_out_d = 1'b0; // Unused encodings recover through reset.
                bus_oe_d   = 1'b0;
                state_d    = intr_ctrl_pkg::reset;
            end
        endcase
    end

    // Control state.
    always_ff @(posedge clk_in or posedge rst_in) begin
        if (rst_in) begin
            state_q  <= intr_ctrl_pkg::reset;
            mode_q   <= intr_bus_pkg::none;
            served_q <= '0;
            intr_out <= 1'b0;
            bus_oe   <= 1'b0;
        end else begin
            state_q  <= state_d;
            mode_q   <= mode_d;
            served_q <= served_d;
            intr_out <= intr_out_d;
            bus_oe   <= bus_oe_d;
        end
    end

    // Vector word, qualified by bus_oe.
    always_ff @(posedge clk_in) begin
        bus_out <= bus_out_d;
    end

endmodule

`default_nettype wire

// ==== hdl/intr_ctrl.sv ====
`default_nettype none

module intr_ctrl (
    input  wire                                clk_in,
    input  wire                                rst_in,
    input  wire [intr_ctrl_pkg::SRC_COUNT-1:0] intr_rq,  // Level requests.
    input  wire intr_bus_pkg::bus_word_u       bus_in,
    input  wire                                intr_in,  // Active-low acknowledge.
    output intr_bus_pkg::bus_word_u            bus_out,  // Valid while bus_oe is high.
    output logic                               intr_out,
    output logic                               bus_oe
);

    intr_ctrl_pkg::src_id_t poll_idx;
    intr_ctrl_pkg::grant_t  grant;
    logic                   load_done;
    logic                   poll_clear;
    logic                   poll_step;
    logic                   table_clear;
    logic                   table_load;

    intr_fsm intr_fsm_inst (
        .clk_in      (clk_in),
        .rst_in      (rst_in),
        .intr_rq     (intr_rq),
        .bus_in      (bus_in),
        .intr_in     (intr_in),
        .poll_idx    (poll_idx),
        .grant       (grant),
        .load_done   (load_done),
        .poll_clear  (poll_clear),
        .poll_step   (poll_step),
        .table_clear (table_clear),
        .table_load  (table_load),
        .intr_out    (intr_out),
        .bus_out     (bus_out),
        .bus_oe      (bus_oe)
    );

    poll_counter poll_counter_inst (
        .clk_in     (clk_in),
        .rst_in     (rst_in),
        .poll_clear (poll_clear),
        .poll_step  (poll_step),
        .poll_idx   (poll_idx)
    );

    priority_table priority_table_inst (
        .clk_in      (clk_in),
        .rst_in      (rst_in),
        .table_clear (table_clear),
        .table_load  (table_load),
        .bus_in      (bus_in),
        .intr_rq     (intr_rq),
        .grant       (grant),
        .load_done   (load_done)
    );

endmodule

`default_nettype wire

// ==== verification/intr_ctrl_tb.sv ====
`default_nettype none

module intr_ctrl_tb;
    timeunit 1ns;
    timeprecision 100ps;

    // One scenario, served once by the processor model.
    typedef struct packed {
        intr_bus_pkg::intr_mode_e mode;
        logic [31:0]              words;    // Priority words, first one in the top byte.
        logic [7:0]               rq;       // Requests that decide the winner.
        logic [7:0]               free;     // Sources that may also request at random.
        intr_ctrl_pkg::src_id_t   exp_id;
        logic [1:0]               bad_done; // Set bits spoil the done code (1) or ID (0).
        intr_bus_pkg::bus_word_u  exp_vec;
    } row_t;

    localparam int ROW_COUNT   = 11;
    localparam int CYCLE_LIMIT = 60 * ROW_COUNT + 100;

    // Poll rows follow the scan from the last served index, prio rows the loaded ranks.
    localparam row_t ROWS [ROW_COUNT] = '{
        '{intr_bus_pkg::poll, 32'h0,        8'h10, 8'he0, 3'd4, 2'b00, 8'h5c}, // Scan from 0.
        '{intr_bus_pkg::poll, 32'h0,        8'h42, 8'h8f, 3'd6, 2'b00, 8'h5e}, // Scan from 4.
        '{intr_bus_pkg::poll, 32'h0,        8'h0a, 8'h3c, 3'd1, 2'b01, 8'h59}, // Wraps past 7.
        '{intr_bus_pkg::poll, 32'h0,        8'h81, 8'hfe, 3'd0, 2'b00, 8'h58},
        '{intr_bus_pkg::poll, 32'h0,        8'h01, 8'hfe, 3'd0, 2'b10, 8'h58}, // Same index.
        '{intr_bus_pkg::prio, 32'haae27a32, 8'h11, 8'h5a, 3'd0, 2'b00, 8'h98}, // Ranks 52703614.
        '{intr_bus_pkg::prio, 32'h0,        8'h24, 8'hdb, 3'd5, 2'b00, 8'h9d},
        '{intr_bus_pkg::prio, 32'h0,        8'h40, 8'h12, 3'd6, 2'b10, 8'h9e},
        '{intr_bus_pkg::prio, 32'h66d21e56, 8'h84, 8'h24, 3'd7, 2'b00, 8'h9f}, // Ranks 31640725.
        '{intr_bus_pkg::prio, 32'h0,        8'h08, 8'hf7, 3'd3, 2'b01, 8'h9b},
        '{intr_bus_pkg::poll, 32'h0,        8'h20, 8'hc0, 3'd5, 2'b00, 8'h5d}  // Back to polling.
    };

    logic                    clk_in;
    logic                    rst_in;
    logic [7:0]              intr_rq;
    intr_bus_pkg::bus_word_u bus_in;
    logic                    intr_in;
    intr_bus_pkg::bus_word_u bus_out;
    logic                    intr_out;
    logic                    bus_oe;
    int                      cycles = 0; // Clock edges since time zero.

    intr_ctrl intr_ctrl_inst (
        .clk_in   (clk_in),
        .rst_in   (rst_in),
        .intr_rq  (intr_rq),
        .bus_in   (bus_in),
        .intr_in  (intr_in),
        .bus_out  (bus_out),
        .intr_out (intr_out),
        .bus_oe   (bus_oe)
    );

    initial begin
        clk_in = 1'b0;
        forever #2 clk_in = ~clk_in; // 4 ns period.
    end

    always @(posedge clk_in) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: controller stopped responding");
            $display("RESULT: FAIL");
            $fatal(1, "cycle limit reached");
        end
    end

    // Inputs change and outputs are sampled 1 ns after the edge.
    task automatic next_cycle();
        @(posedge clk_in);
        #1;
    endtask

    task automatic check_word(input string name, input intr_bus_pkg::bus_word_u exp,
                              input intr_bus_pkg::bus_word_u got);
        if (got !== exp) begin
            $display("mismatch %s exp %h got %h", name, exp, got);
            $display("RESULT: FAIL");
            $fatal(1, "word compare failed");
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic got);
        if (got !== exp) begin
            $display("mismatch %s exp %h got %h", name, exp, got);
            $display("RESULT: FAIL");
            $fatal(1, "bit compare failed");
        end
    endtask

    task automatic drive_idle();
        bus_in  = '0; // Mode bits none, ignored in cmd.
        intr_in = 1'b1;
    endtask

    // Without a command all requests must go unanswered.
    task automatic check_quiet();
        intr_rq = 8'hff;
        repeat (4) begin
            next_cycle();
            check_bit("intr_out", 1'b0, intr_out);
            check_bit("bus_oe", 1'b0, bus_oe);
        end
        intr_rq = '0;
    endtask

    task automatic send_command(input row_t row);
        next_cycle(); // Lets a pending reset state pass.
        if (row.mode == intr_bus_pkg::poll) begin
            bus_in.cmd.mode = intr_bus_pkg::poll;
            next_cycle();
        end else begin
            for (int i = 3; i >= 0; i--) begin
                bus_in = row.words[i*8 +: 8]; // One rank pair per cycle.
                next_cycle();
            end
        end
        drive_idle();
    endtask

    // Processor side of one interrupt, from request to done word.
    task automatic serve_row(input row_t row);
        logic [31:0]             rnd;
        intr_bus_pkg::bus_word_u done;
        rnd     = $urandom();
        intr_rq = row.rq | (rnd[7:0] & row.free);
        while (intr_out !== 1'b1) begin
            next_cycle();
        end
        check_bit("bus_oe", 1'b0, bus_oe);
        intr_in = 1'b0; // First acknowledge.
        next_cycle();
        intr_in = 1'b1;
        while (bus_oe !== 1'b1) begin
            next_cycle();
        end
        check_bit("intr_out", 1'b0, intr_out);
        check_word("bus_out", row.exp_vec, bus_out);
        intr_in = 1'b0; // Second acknowledge frees the bus.
        next_cycle();
        intr_in = 1'b1;
        while (bus_oe !== 1'b0) begin
            next_cycle();
        end
        check_bit("intr_out", 1'b0, intr_out);
        intr_rq       = '0;
        done.msg.code = (row.mode == intr_bus_pkg::poll) ? intr_bus_pkg::POLL_DONE_CODE
                                                         : intr_bus_pkg::PRIO_DONE_CODE;
        done.msg.code = done.msg.code ^ {4'b0, row.bad_done[1]};
        done.msg.id   = row.exp_id ^ {2'b0, row.bad_done[0]};
        bus_in        = done;
        intr_in       = 1'b0;
        next_cycle();
        drive_idle(); // Next row's requests follow in this same step.
    endtask

    initial begin
        logic need_cmd;
        void'($urandom(32'hc70d));
        rst_in  = 1'b1;
        intr_rq = '0;
        drive_idle();
        repeat (2) @(posedge clk_in);
        #1;
        rst_in   = 1'b0;
        check_quiet(); // Controller waits in cmd after reset.
        need_cmd = 1'b1;
        for (int r = 0; r < ROW_COUNT; r++) begin
            if (need_cmd) begin
                send_command(ROWS[r]);
            end
            serve_row(ROWS[r]);
            need_cmd = |ROWS[r].bad_done; // Wrong done word means back to reset.
            if (need_cmd) begin
                check_quiet();
            end
        end
        $display("RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
hdl/intr_bus_pkg.sv
hdl/intr_ctrl_pkg.sv
hdl/poll_counter.sv
hdl/priority_table.sv
hdl/intr_fsm.sv
hdl/intr_ctrl.sv
verification/intr_ctrl_tb.sv

// ==== Makefile ====
TOP = intr_ctrl_tb

.PHONY: all compile run clean

all: run

compile: obj_dir/V$(TOP)

obj_dir/V$(TOP): vlog.f $(shell cat vlog.f)
	verilator --binary --timing --timescale 1ns/100ps -f vlog.f --top-module $(TOP) -Mdir obj_dir

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
